// ==== Bender.yml ====
package:
  name: cpu_bus_datapath

sources:
  - files:
      - rtl/cpu_isa_pkg.sv
      - rtl/cpu_ctrl_pkg.sv
      - rtl/datapath_if.sv
      - rtl/alu_if.sv
      - rtl/control_unit.sv
      - rtl/reg_bus_datapath.sv
      - rtl/alu.sv
      - rtl/cpu_top.sv
  - target: test
    files:
      - dv/cpu_tb_asserts.sv
      - dv/cpu_tb.sv

// ==== dv/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam cpu_isa_pkg::word_t RESET_PC = 32'h0000_0040;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int MEM_AW       = 10;
    localparam int TOTAL_INSTR  = 107;   // Sum of all program lengths below

    logic               clk;
    logic               reset;
    cpu_isa_pkg::word_t mem_addr;
    logic               mem_read;
    cpu_isa_pkg::word_t mem_rdata;
    logic               mem_write;
    cpu_isa_pkg::word_t mem_wdata;
    logic               halted;

    cpu_isa_pkg::word_t  mem [2**MEM_AW];
    cpu_isa_pkg::instr_t prog [$];
    cpu_isa_pkg::word_t  exp_st_addr [$];
    cpu_isa_pkg::word_t  exp_st_data [$];
    int                  exp_gaps [$];     // Cycles between fetches, per instruction
    int                  exp_fetches;
    cpu_isa_pkg::word_t  st_addr [$];
    cpu_isa_pkg::word_t  st_data [$];
    int                  fetch_cycles [$];
    cpu_isa_pkg::word_t  first_fetch_addr;
    logic                first_fetch_halted;
    logic                read_q;
    logic                late_access;      // Memory strobe seen while halted
    int                  cycle = 0;
    int                  test_errors = 0;
    int                  pass_count = 0;
    int                  fail_count = 0;

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) i_cpu_top (
        .clk       (clk),
        .reset     (reset),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_rdata (mem_rdata),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .halted    (halted)
    );

    // Memory answers within the cycle
    assign mem_rdata = mem_read ? mem[mem_addr[MEM_AW-1:0]] : '0;

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Bus monitor for fetch edges, stores and accesses after halt
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (reset)
            read_q = 1'b0;
        else
        begin
            if (mem_read && !read_q)
            begin
                if (fetch_cycles.size() == 0)
                begin
                    first_fetch_addr   = mem_addr;
                    first_fetch_halted = halted;
                end
                fetch_cycles.push_back(cycle);
            end
            if (mem_write)
            begin
                st_addr.push_back(mem_addr);
                st_data.push_back(mem_wdata);
            end
            if (halted && (mem_read || mem_write))
                late_access = 1'b1;
            read_q = mem_read;
        end
    end

    function automatic cpu_isa_pkg::instr_t reg_instr(cpu_isa_pkg::opcode_e op,
        cpu_isa_pkg::reg_idx_t ra, cpu_isa_pkg::reg_idx_t rb, cpu_isa_pkg::reg_idx_t rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic cpu_isa_pkg::instr_t imm_instr(cpu_isa_pkg::opcode_e op,
        cpu_isa_pkg::reg_idx_t ra, logic [18:0] imm);
        return {op, ra, 4'd0, imm};
    endfunction

    function automatic cpu_isa_pkg::instr_t halt_instr();
        return {cpu_isa_pkg::OP_HALT, 27'd0};
    endfunction

    function automatic logic [18:0] rand_imm();
        return 19'($urandom());
    endfunction

    // ISA reference model with register effects, stores and step counts per instruction
    task automatic run_model();
        cpu_isa_pkg::word_t    r [16];
        cpu_isa_pkg::instr_t   ins;
        logic [4:0]            op;
        cpu_isa_pkg::reg_idx_t ra;
        cpu_isa_pkg::reg_idx_t rb;
        cpu_isa_pkg::reg_idx_t rc;
        cpu_isa_pkg::word_t    imm;
        logic                  done;
        foreach (r[i])
            r[i] = '0;
        exp_st_addr.delete();
        exp_st_data.delete();
        exp_gaps.delete();
        exp_fetches = 0;
        done = 1'b0;
        for (int i = 0; i < prog.size() && !done; i++)
        begin
            ins = prog[i];
            op  = ins[31:27];
            ra  = ins[26:23];
            rb  = ins[22:19];
            rc  = ins[18:15];
            imm = {{13{ins[18]}}, ins[18:0]};
            exp_fetches++;
            case (op)
                cpu_isa_pkg::OP_ADD: r[ra] = r[rb] + r[rc];
                cpu_isa_pkg::OP_SUB: r[ra] = r[rb] - r[rc];
                cpu_isa_pkg::OP_AND: r[ra] = r[rb] & r[rc];
                cpu_isa_pkg::OP_OR:  r[ra] = r[rb] | r[rc];
                cpu_isa_pkg::OP_SHL: r[ra] = r[rb] << r[rc][4:0];
                cpu_isa_pkg::OP_SHR: r[ra] = r[rb] >> r[rc][4:0];
                cpu_isa_pkg::OP_NOT: r[ra] = ~r[rb];
                cpu_isa_pkg::OP_NEG: r[ra] = 32'd0 - r[rb];
                cpu_isa_pkg::OP_LDI: r[ra] = imm;
                cpu_isa_pkg::OP_ST:
                begin
                    exp_st_addr.push_back(imm);
                    exp_st_data.push_back(r[ra]);
                end
                default: done = 1'b1;   // HALT
            endcase
            if (op == cpu_isa_pkg::OP_LDI)
                exp_gaps.push_back(4);
            else if (op == cpu_isa_pkg::OP_NOT || op == cpu_isa_pkg::OP_NEG)
                exp_gaps.push_back(5);
            else
                exp_gaps.push_back(6);
        end
    endtask

    // Reset the DUT around a fresh memory image, then wait for halted
    task automatic load_and_run();
        int   limit;
        logic seen;
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (int a = 0; a < 2**MEM_AW; a++)
            mem[a] = {cpu_isa_pkg::OP_HALT, 27'(a)};   // Runaway fetches halt
        for (int i = 0; i < prog.size(); i++)
            mem[RESET_PC[MEM_AW-1:0] + i] = prog[i];
        fetch_cycles.delete();
        st_addr.delete();
        st_data.delete();
        late_access      = 1'b0;
        first_fetch_addr = 'x;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        limit = prog.size() * 6 + 8;
        seen  = 1'b0;
        for (int c = 0; c < limit && !seen; c++)
        begin
            @(posedge clk);
            seen = halted;
        end
        if (!seen)
        begin
            $display("%0t: halted did not rise within %0d cycles", $time, limit);
            test_errors++;
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic report_mismatch(string sig, cpu_isa_pkg::word_t exp, cpu_isa_pkg::word_t act);
        $display("[ERROR] %0t %s expected 0x%h actual 0x%h", $time, sig, exp, act);
        test_errors++;
    endtask

    task automatic compare_results();
        int n;
        if (st_addr.size() != exp_st_addr.size())
        begin
            $display("%0t: expected %0d stores but saw %0d", $time,
                     exp_st_addr.size(), st_addr.size());
            test_errors++;
        end
        n = (st_addr.size() < exp_st_addr.size()) ? st_addr.size() : exp_st_addr.size();
        for (int k = 0; k < n; k++)
        begin
            if (st_addr[k] !== exp_st_addr[k])
                report_mismatch("mem_addr", exp_st_addr[k], st_addr[k]);
            if (st_data[k] !== exp_st_data[k])
                report_mismatch("mem_wdata", exp_st_data[k], st_data[k]);
        end
        if (fetch_cycles.size() != exp_fetches)
            report_mismatch("mem_read count", exp_fetches, fetch_cycles.size());
        n = (fetch_cycles.size() < exp_fetches) ? fetch_cycles.size() : exp_fetches;
        for (int k = 0; k + 1 < n; k++)
        begin
            if (fetch_cycles[k+1] - fetch_cycles[k] != exp_gaps[k])
                report_mismatch("mem_read interval", exp_gaps[k],
                                fetch_cycles[k+1] - fetch_cycles[k]);
        end
        if (late_access)
        begin
            $display("%0t: memory was accessed while halted", $time);
            test_errors++;
        end
    endtask

    task automatic close_test(string name);
        if (test_errors == 0)
        begin
            pass_count++;
            $display("PASS  %s", name);
        end
        else
        begin
            fail_count++;
            $display("FAIL  %s (%0d errors)", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic execute_program();
        run_model();
        load_and_run();
        compare_results();
    endtask

    task automatic first_fetch_test();
        prog.delete();
        prog.push_back(imm_instr(cpu_isa_pkg::OP_LDI, 4'd0, rand_imm()));
        prog.push_back(imm_instr(cpu_isa_pkg::OP_ST, 4'd0, 19'h00300));
        prog.push_back(halt_instr());
        execute_program();
        if (first_fetch_addr !== RESET_PC)
            report_mismatch("mem_addr", RESET_PC, first_fetch_addr);
        if (first_fetch_halted !== 1'b0)
            report_mismatch("halted", 32'd0, first_fetch_halted);
        close_test("first fetch from RESET_PC");
    endtask

    task automatic ldi_store_test();
        prog.delete();
        for (int i = 0; i < 8; i++)
            prog.push_back(imm_instr(cpu_isa_pkg::OP_LDI, 4'(2 * i), rand_imm()));
        for (int i = 0; i < 8; i++)
            prog.push_back(imm_instr(cpu_isa_pkg::OP_ST, 4'(2 * i), rand_imm()));
        prog.push_back(halt_instr());
        execute_program();
        close_test("LDI then ST");
    endtask

    task automatic two_operand_test();
        cpu_isa_pkg::opcode_e ops [6] = '{cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_SUB,
            cpu_isa_pkg::OP_AND, cpu_isa_pkg::OP_OR, cpu_isa_pkg::OP_SHL, cpu_isa_pkg::OP_SHR};
        prog.delete();
        for (int i = 0; i < 16; i++)
            prog.push_back(imm_instr(cpu_isa_pkg::OP_LDI, 4'(i), rand_imm()));
        for (int i = 0; i < 20; i++)
            prog.push_back(reg_instr(ops[$urandom_range(5, 0)], 4'($urandom()),
                                     4'($urandom()), 4'($urandom())));
        for (int i = 0; i < 16; i++)
            prog.push_back(imm_instr(cpu_isa_pkg::OP_ST, 4'(i), 19'h00200 + 19'(i)));
        prog.push_back(halt_instr());
        execute_program();
        close_test("random two-operand program");
    endtask

    task automatic unary_test();
        prog.delete();
        // Build 0xF0F0F0F0 in r3, then NOT into r4
        prog.push_back(imm_instr(cpu_isa_pkg::OP_LDI, 4'd1, 19'h0F0F0));
        prog.push_back(imm_instr(cpu_isa_pkg::OP_LDI, 4'd2, 19'd16));
        prog.push_back(reg_instr(cpu_isa_pkg::OP_SHL, 4'd3, 4'd1, 4'd2));
        prog.push_back(reg_instr(cpu_isa_pkg::OP_OR, 4'd3, 4'd3, 4'd1));
        prog.push_back(reg_instr(cpu_isa_pkg::OP_NOT, 4'd4, 4'd3, 4'd0));
        prog.push_back(imm_instr(cpu_isa_pkg::OP_ST, 4'd4, 19'h00240));
        for (int i = 0; i < 4; i++)
            prog.push_back(imm_instr(cpu_isa_pkg::OP_LDI, 4'(8 + i), rand_imm()));
        for (int i = 0; i < 4; i++)
            prog.push_back(reg_instr((i % 2 == 0) ? cpu_isa_pkg::OP_NOT : cpu_isa_pkg::OP_NEG,
                                     4'(12 + i), 4'(8 + i), 4'd0));
        for (int i = 0; i < 4; i++)
            prog.push_back(imm_instr(cpu_isa_pkg::OP_ST, 4'(12 + i), 19'h00241 + 19'(i)));
        prog.push_back(halt_instr());
        execute_program();
        if (st_data.size() > 0 && st_data[0] !== 32'h0F0F_0F0F)
            report_mismatch("mem_wdata", 32'h0F0F_0F0F, st_data[0]);
        close_test("NOT and NEG");
    endtask

    task automatic halt_test();
        prog.delete();
        prog.push_back(imm_instr(cpu_isa_pkg::OP_LDI, 4'd3, rand_imm()));
        prog.push_back(imm_instr(cpu_isa_pkg::OP_ST, 4'd3, 19'h00280));
        prog.push_back(halt_instr());
        prog.push_back(imm_instr(cpu_isa_pkg::OP_ST, 4'd3, 19'h00281));   // Never reached
        prog.push_back(imm_instr(cpu_isa_pkg::OP_ST, 4'd3, 19'h00282));
        execute_program();
        if (halted !== 1'b1)
            report_mismatch("halted", 32'd1, halted);
        close_test("HALT stops fetching");
    endtask

    task automatic timing_test();
        prog.delete();
        prog.push_back(imm_instr(cpu_isa_pkg::OP_LDI, 4'd1, rand_imm()));
        prog.push_back(imm_instr(cpu_isa_pkg::OP_LDI, 4'd2, rand_imm()));
        prog.push_back(reg_instr(cpu_isa_pkg::OP_ADD, 4'd3, 4'd1, 4'd2));
        prog.push_back(reg_instr(cpu_isa_pkg::OP_NEG, 4'd4, 4'd3, 4'd0));
        prog.push_back(imm_instr(cpu_isa_pkg::OP_ST, 4'd3, 19'h002C0));
        prog.push_back(reg_instr(cpu_isa_pkg::OP_NOT, 4'd5, 4'd4, 4'd0));
        prog.push_back(imm_instr(cpu_isa_pkg::OP_ST, 4'd5, 19'h002C1));
        prog.push_back(reg_instr(cpu_isa_pkg::OP_SUB, 4'd6, 4'd1, 4'd4));
        prog.push_back(imm_instr(cpu_isa_pkg::OP_ST, 4'd6, 19'h002C2));
        prog.push_back(halt_instr());
        execute_program();
        close_test("step counts per class");
    endtask

    // Watchdog
    initial
    begin
        #(TOTAL_INSTR * 6 * CLK_PERIOD + 1000);
        $display("Run exceeded its time budget at %0t", $time);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(32'hbdeb_0134));
        reset = 1'b1;
        first_fetch_test();
        ldi_store_test();
        two_operand_test();
        unary_test();
        halt_test();
        timing_test();
        if (i_cpu_top.i_cpu_tb_asserts.assert_failures != 0)
        begin
            $display("%0d assertion failures on the bus strobes",
                     i_cpu_top.i_cpu_tb_asserts.assert_failures);
            fail_count++;
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/cpu_tb_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb_asserts (
    input logic clk,
    input logic reset,
    input logic mem_read,
    input logic mem_write,
    input logic halted
);

    int assert_failures = 0;   // Failed assertions so far

    a_read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write))
    else
    begin
        assert_failures++;
        $error("mem_read and mem_write high together");
    end

    // A store strobe lasts one cycle
    a_write_single: assert property (@(posedge clk) disable iff (reset)
        mem_write |=> !mem_write)
    else
    begin
        assert_failures++;
        $error("mem_write high for two cycles");
    end

    a_halted_sticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
    else
    begin
        assert_failures++;
        $error("halted dropped without reset");
    end

    a_quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
        halted |-> (!mem_read && !mem_write))
    else
    begin
        assert_failures++;
        $error("memory strobe while halted");
    end

endmodule

bind cpu_top cpu_tb_asserts i_cpu_tb_asserts (
    .clk       (clk),
    .reset     (reset),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .halted    (halted)
);

`default_nettype wire

// ==== filelist.f ====
rtl/cpu_isa_pkg.sv
rtl/cpu_ctrl_pkg.sv
rtl/datapath_if.sv
rtl/alu_if.sv
rtl/control_unit.sv
rtl/reg_bus_datapath.sv
rtl/alu.sv
rtl/cpu_top.sv
dv/cpu_tb_asserts.sv
dv/cpu_tb.sv

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    alu_if.fu alu_port
);

    logic [4:0] shamt;   // Shift distance from the bus

    assign shamt = alu_port.bus_val[4:0];

    always_comb
    begin
        case (alu_port.op)
            cpu_ctrl_pkg::ALU_ADD:
                alu_port.result = alu_port.y + alu_port.bus_val;
            cpu_ctrl_pkg::ALU_SUB:
                alu_port.result = alu_port.y - alu_port.bus_val;
            cpu_ctrl_pkg::ALU_AND:
                alu_port.result = alu_port.y & alu_port.bus_val;
            cpu_ctrl_pkg::ALU_OR:
                alu_port.result = alu_port.y | alu_port.bus_val;
            cpu_ctrl_pkg::ALU_SHL:
                alu_port.result = alu_port.y << shamt;   // Logical, zero fill
            cpu_ctrl_pkg::ALU_SHR:
                alu_port.result = alu_port.y >> shamt;
            // Unary ops ignore Y
            cpu_ctrl_pkg::ALU_NOT:
                alu_port.result = ~alu_port.bus_val;
            cpu_ctrl_pkg::ALU_NEG:
                alu_port.result = '0 - alu_port.bus_val;
            default:
                alu_port.result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/alu_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface alu_if;

    cpu_isa_pkg::word_t    y;        // Left operand
    cpu_isa_pkg::word_t    bus_val;  // Right operand, current bus value
    cpu_ctrl_pkg::alu_op_e op;
    cpu_isa_pkg::word_t    result;

    modport src (output y, bus_val, op, input result);
    modport fu  (input y, bus_val, op, output result);

endinterface

`default_nettype wire

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic       clk,
    input  logic       reset,
    datapath_if.ctrl   ctrl,
    output logic       halted
);

    cpu_ctrl_pkg::step_e   step;
    cpu_ctrl_pkg::step_e   step_next;
    cpu_isa_pkg::opcode_e  opcode;
    cpu_isa_pkg::reg_idx_t ra;
    cpu_isa_pkg::reg_idx_t rb;
    cpu_isa_pkg::reg_idx_t rc;
    cpu_ctrl_pkg::alu_op_e op_alu;
    logic                  two_op;   // ADD SUB AND OR SHL SHR
    logic                  unary;    // NOT NEG

    assign opcode = cpu_isa_pkg::opcode_e'(ctrl.ir[cpu_isa_pkg::OPCODE_MSB:cpu_isa_pkg::OPCODE_LSB]);
    assign ra     = ctrl.ir[cpu_isa_pkg::RA_MSB:cpu_isa_pkg::RA_LSB];
    assign rb     = ctrl.ir[cpu_isa_pkg::RB_MSB:cpu_isa_pkg::RB_LSB];
    assign rc     = ctrl.ir[cpu_isa_pkg::RC_MSB:cpu_isa_pkg::RC_LSB];

    // Opcode to ALU operation and instruction class
    always_comb
    begin
        two_op = 1'b1;
        unary  = 1'b0;
        op_alu = cpu_ctrl_pkg::ALU_ADD;
        case (opcode)
            cpu_isa_pkg::OP_ADD: op_alu = cpu_ctrl_pkg::ALU_ADD;
            cpu_isa_pkg::OP_SUB: op_alu = cpu_ctrl_pkg::ALU_SUB;
            cpu_isa_pkg::OP_AND: op_alu = cpu_ctrl_pkg::ALU_AND;
            cpu_isa_pkg::OP_OR:  op_alu = cpu_ctrl_pkg::ALU_OR;
            cpu_isa_pkg::OP_SHL: op_alu = cpu_ctrl_pkg::ALU_SHL;
            cpu_isa_pkg::OP_SHR: op_alu = cpu_ctrl_pkg::ALU_SHR;
            cpu_isa_pkg::OP_NOT:
            begin
                op_alu = cpu_ctrl_pkg::ALU_NOT;
                two_op = 1'b0;
                unary  = 1'b1;
            end
            cpu_isa_pkg::OP_NEG:
            begin
                op_alu = cpu_ctrl_pkg::ALU_NEG;
                two_op = 1'b0;
                unary  = 1'b1;
            end
            default: two_op = 1'b0;   // LDI, ST, HALT, unknown
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            step <= cpu_ctrl_pkg::STEP_T0;
        else
            step <= step_next;
    end

    assign halted = (step == cpu_ctrl_pkg::STEP_HALTED);

    // Control word for the current step
    always_comb
    begin
        step_next         = step;
        ctrl.bus_src      = cpu_ctrl_pkg::BUS_NONE;
        ctrl.gpr_sel      = '0;
        ctrl.pc_in        = 1'b0;
        ctrl.ir_in        = 1'b0;
        ctrl.mar_in       = 1'b0;
        ctrl.mdr_in       = 1'b0;
        ctrl.y_in         = 1'b0;
        ctrl.z_in         = 1'b0;
        ctrl.gpr_in       = 1'b0;
        ctrl.mdr_from_mem = 1'b0;
        ctrl.alu_op       = cpu_ctrl_pkg::ALU_ADD;
        ctrl.mem_read     = 1'b0;
        ctrl.mem_write    = 1'b0;
        case (step)
            cpu_ctrl_pkg::STEP_T0:
            begin
                ctrl.bus_src = cpu_ctrl_pkg::BUS_PC;   // PC to MAR, PC + 1 into Z
                ctrl.mar_in  = 1'b1;
                ctrl.z_in    = 1'b1;
                step_next    = cpu_ctrl_pkg::STEP_T1;
            end
            cpu_ctrl_pkg::STEP_T1:
            begin
                ctrl.mem_read     = 1'b1;
                ctrl.mdr_in       = 1'b1;
                ctrl.mdr_from_mem = 1'b1;
                ctrl.bus_src      = cpu_ctrl_pkg::BUS_ZLOW;
                ctrl.pc_in        = 1'b1;
                step_next         = cpu_ctrl_pkg::STEP_T2;
            end
            cpu_ctrl_pkg::STEP_T2:
            begin
                ctrl.bus_src = cpu_ctrl_pkg::BUS_MDR;
                ctrl.ir_in   = 1'b1;
                step_next    = cpu_ctrl_pkg::STEP_T3;
            end
            cpu_ctrl_pkg::STEP_T3:
            begin
                if (two_op)
                begin
                    ctrl.bus_src = cpu_ctrl_pkg::BUS_GPR;  // rb into Y
                    ctrl.gpr_sel = rb;
                    ctrl.y_in    = 1'b1;
                    step_next    = cpu_ctrl_pkg::STEP_T4;
                end
                else if (unary)
                begin
                    ctrl.bus_src = cpu_ctrl_pkg::BUS_GPR;
                    ctrl.gpr_sel = rb;
                    ctrl.alu_op  = op_alu;
                    ctrl.z_in    = 1'b1;
                    step_next    = cpu_ctrl_pkg::STEP_T4;
                end
                else if (opcode == cpu_isa_pkg::OP_LDI)
                begin
                    ctrl.bus_src = cpu_ctrl_pkg::BUS_IMM;
                    ctrl.gpr_sel = ra;
                    ctrl.gpr_in  = 1'b1;
                    step_next    = cpu_ctrl_pkg::STEP_T0;
                end
                else if (opcode == cpu_isa_pkg::OP_ST)
                begin
                    ctrl.bus_src = cpu_ctrl_pkg::BUS_IMM;  // Store address
                    ctrl.mar_in  = 1'b1;
                    step_next    = cpu_ctrl_pkg::STEP_T4;
                end
                else
                    step_next = cpu_ctrl_pkg::STEP_HALTED;  // HALT or unknown opcode
            end
            cpu_ctrl_pkg::STEP_T4:
            begin
                ctrl.bus_src = cpu_ctrl_pkg::BUS_GPR;
                step_next    = cpu_ctrl_pkg::STEP_T5;
                if (two_op)
                begin
                    ctrl.gpr_sel = rc;
                    ctrl.alu_op  = op_alu;
                    ctrl.z_in    = 1'b1;
                end
                else if (unary)
                begin
                    ctrl.bus_src = cpu_ctrl_pkg::BUS_ZLOW;
                    ctrl.gpr_sel = ra;
                    ctrl.gpr_in  = 1'b1;
                    step_next    = cpu_ctrl_pkg::STEP_T0;
                end
                else
                begin
                    ctrl.gpr_sel = ra;   // ST data into MDR
                    ctrl.mdr_in  = 1'b1;
                end
            end
            cpu_ctrl_pkg::STEP_T5:
            begin
                step_next = cpu_ctrl_pkg::STEP_T0;
                if (two_op)
                begin
                    ctrl.bus_src = cpu_ctrl_pkg::BUS_ZLOW;
                    ctrl.gpr_sel = ra;
                    ctrl.gpr_in  = 1'b1;
                end
                else
                    ctrl.mem_write = 1'b1;
            end
            default: step_next = cpu_ctrl_pkg::STEP_HALTED;  // Stays here until reset
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_ctrl_pkg.sv ====
`default_nettype none

package cpu_ctrl_pkg;

    localparam int STEP_W    = 3;
    localparam int BUS_SRC_W = 3;
    localparam int ALU_OP_W  = 3;

    // One control step per clock, HALTED is terminal until reset
    typedef enum logic [STEP_W-1:0] {
        STEP_T0,
        STEP_T1,
        STEP_T2,
        STEP_T3,
        STEP_T4,
        STEP_T5,
        STEP_HALTED
    } step_e;

    // Register that drives the shared bus
    typedef enum logic [BUS_SRC_W-1:0] {
        BUS_NONE,
        BUS_PC,
        BUS_MDR,
        BUS_ZLOW,
        BUS_GPR,
        BUS_IMM    // Sign-extended immediate from IR
    } bus_src_e;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SHL,
        ALU_SHR,
        ALU_NOT,
        ALU_NEG
    } alu_op_e;

endpackage

`default_nettype wire

// ==== rtl/cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 4;
    localparam int OPCODE_W  = 5;
    localparam int IMM_W     = 19;

    typedef logic [WORD_W-1:0]    word_t;    // Data or address word
    typedef logic [WORD_W-1:0]    instr_t;   // Raw instruction word
    typedef logic [REG_IDX_W-1:0] reg_idx_t; // R0 to R15
    typedef logic [IMM_W-1:0]     imm_t;     // Immediate field before sign extension

    // Instruction field positions
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 27;
    localparam int RA_MSB     = 26;  // Destination, or store source
    localparam int RA_LSB     = 23;
    localparam int RB_MSB     = 22;
    localparam int RB_LSB     = 19;
    localparam int RC_MSB     = 18;
    localparam int RC_LSB     = 15;
    localparam int IMM_MSB    = 18;
    localparam int IMM_LSB    = 0;

    typedef enum logic [OPCODE_W-1:0] {
        OP_LDI  = 5'd1,
        OP_ST   = 5'd2,
        OP_ADD  = 5'd3,
        OP_SUB  = 5'd4,
        OP_SHR  = 5'd5,
        OP_SHL  = 5'd7,
        OP_AND  = 5'd10,
        OP_OR   = 5'd11,
        OP_NEG  = 5'd17,
        OP_NOT  = 5'd18,
        OP_HALT = 5'd27
    } opcode_e;

endpackage

`default_nettype wire

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter cpu_isa_pkg::word_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               reset,
    output cpu_isa_pkg::word_t mem_addr,
    output logic               mem_read,
    input  cpu_isa_pkg::word_t mem_rdata,
    output logic               mem_write,
    output cpu_isa_pkg::word_t mem_wdata,
    output logic               halted
);

    datapath_if u_dp_if ();
    alu_if      u_alu_if ();

    // Memory strobes come straight from the control word
    assign mem_read  = u_dp_if.mem_read;
    assign mem_write = u_dp_if.mem_write;

    control_unit i_control_unit (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (u_dp_if.ctrl),
        .halted (halted)
    );

    reg_bus_datapath #(
        .RESET_PC (RESET_PC)
    ) i_reg_bus_datapath (
        .clk       (clk),
        .reset     (reset),
        .dp        (u_dp_if.dp),
        .alu_port  (u_alu_if.src),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    alu i_alu (
        .alu_port (u_alu_if.fu)
    );

endmodule

`default_nettype wire

// ==== rtl/datapath_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Control word from the sequencer, IR back from the register block
interface datapath_if;

    cpu_ctrl_pkg::bus_src_e bus_src;
    cpu_isa_pkg::reg_idx_t  gpr_sel;
    logic                   pc_in;
    logic                   ir_in;
    logic                   mar_in;
    logic                   mdr_in;
    logic                   y_in;
    logic                   z_in;
    logic                   gpr_in;
    logic                   mdr_from_mem;  // MDR loads from memory, not the bus
    cpu_ctrl_pkg::alu_op_e  alu_op;
    logic                   mem_read;
    logic                   mem_write;
    cpu_isa_pkg::instr_t    ir;

    modport ctrl (
        output bus_src, gpr_sel, pc_in, ir_in, mar_in, mdr_in, y_in, z_in, gpr_in,
        output mdr_from_mem, alu_op, mem_read, mem_write,
        input  ir
    );

    // Memory strobes go straight to the top-level ports
    modport dp (
        input  bus_src, gpr_sel, pc_in, ir_in, mar_in, mdr_in, y_in, z_in, gpr_in,
        input  mdr_from_mem, alu_op,
        output ir
    );

endinterface

`default_nettype wire

// ==== rtl/reg_bus_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_bus_datapath #(
    parameter cpu_isa_pkg::word_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               reset,
    datapath_if.dp             dp,
    alu_if.src                 alu_port,
    input  cpu_isa_pkg::word_t mem_rdata,
    output cpu_isa_pkg::word_t mem_addr,
    output cpu_isa_pkg::word_t mem_wdata
);

    cpu_isa_pkg::word_t  pc;
    cpu_isa_pkg::instr_t ir;
    cpu_isa_pkg::word_t  mar;
    cpu_isa_pkg::word_t  mdr;
    cpu_isa_pkg::word_t  y;
    cpu_isa_pkg::word_t  z;
    cpu_isa_pkg::word_t  gpr [16];
    cpu_isa_pkg::word_t  bus;
    cpu_isa_pkg::imm_t   imm;
    cpu_isa_pkg::word_t  imm_ext;

    assign imm     = ir[cpu_isa_pkg::IMM_MSB:cpu_isa_pkg::IMM_LSB];
    assign imm_ext = {{(cpu_isa_pkg::WORD_W - cpu_isa_pkg::IMM_W){imm[cpu_isa_pkg::IMM_W-1]}}, imm};

    // Shared bus
    always_comb
    begin
        case (dp.bus_src)
            cpu_ctrl_pkg::BUS_PC:   bus = pc;
            cpu_ctrl_pkg::BUS_MDR:  bus = mdr;
            cpu_ctrl_pkg::BUS_ZLOW: bus = z;
            cpu_ctrl_pkg::BUS_GPR:  bus = gpr[dp.gpr_sel];
            cpu_ctrl_pkg::BUS_IMM:  bus = imm_ext;
            default:                bus = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= RESET_PC;
        else if (dp.pc_in)
            pc <= bus;
    end

    always_ff @(posedge clk)
    begin
        if (dp.ir_in)
            ir <= bus;
        if (dp.mar_in)
            mar <= bus;
        if (dp.mdr_in)
            mdr <= dp.mdr_from_mem ? mem_rdata : bus;
        if (dp.y_in)
            y <= bus;
        if (dp.z_in)
            z <= alu_port.result;
        if (dp.gpr_in)
            gpr[dp.gpr_sel] <= bus;
    end

    // PC increment: only T0 puts PC on the bus, then the left operand is one
    assign alu_port.y       = (dp.bus_src == cpu_ctrl_pkg::BUS_PC) ? cpu_isa_pkg::word_t'(1) : y;
    assign alu_port.bus_val = bus;
    assign alu_port.op      = dp.alu_op;

    assign dp.ir     = ir;
    assign mem_addr  = mar;
    assign mem_wdata = mdr;

endmodule

`default_nettype wire
